/* compile.f */
verilog/smc_pkg.sv
verilog/smc_apb_regs.sv
verilog/smc_access_ctrl.sv
verilog/smc_addr_gen.sv
verilog/smc_top.sv
sim/smc_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the controller testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module smc_tb -f compile.f -o smc_sim
out=$(./obj_dir/smc_sim)
echo "$out"
if echo "$out" | grep -q "^Regression passed$"
then
   exit 0
else
   exit 1
fi

/* sim/smc_tb.sv */
/* Controller testbench: vectors from sim/smc_vectors.txt, then LFSR requests.
   Bus width code 3 is never driven; the model covers codes 0 to 2 only. */

module smc_tb import smc_pkg::*;
();
   localparam int NRAND = 24;                   // Random phase requests

   logic sys_clk17, n_sys_reset17;
   logic psel, penable, pwrite, pready, pslverr, req_valid, req_ready, done;
   addr_t paddr;
   logic [31:0] pwdata, prdata;
   smc_req_t req;
   emi_t emi;
   bank_cfg_t mirror [NUM_BANKS];               // Model copy of the registers
   logic [31:0] lfsr = 32'h3894fed0;
   int errs = 0, tests = 0, failed = 0;
   int q_kind[$], q_b[$], q_w[$], q_s[$], q_n[$];
   logic [31:0] q_addr[$], q_be[$];

   smc_top DUT (.*);

   initial
   begin
      sys_clk17 = 1'b0;
      forever #10 sys_clk17 = ~sys_clk17;
   end

   // ----------------------------------------
   // Compare tasks
   // ----------------------------------------
   task automatic check_addr(input string n, input addr_t got, input addr_t exp);
      if (got !== exp)
      begin
         errs++;
         $display("Mismatch %s: got %h expected %h", n, got, exp);
      end
   endtask
   task automatic check_be(input string n, input be_t got, input be_t exp);
      if (got !== exp)
      begin
         errs++;
         $display("Mismatch %s: got %h expected %h", n, got, exp);
      end
   endtask
   task automatic check_cs(input string n, input cs_t got, input cs_t exp);
      if (got !== exp)
      begin
         errs++;
         $display("Mismatch %s: got %h expected %h", n, got, exp);
      end
   endtask
   task automatic check_count(input string n, input acc_cnt_t got, input acc_cnt_t exp);
      if (got !== exp)
      begin
         errs++;
         $display("Mismatch %s: got %h expected %h", n, got, exp);
      end
   endtask
   task automatic check_word(input string n, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp)
      begin
         errs++;
         $display("Mismatch %s: got %h expected %h", n, got, exp);
      end
   endtask

   // ----------------------------------------
   // Rule model
   // ----------------------------------------
   function automatic int model_n(input size_t xs, input size_t bs);
      if (xs == SIZE_32 && bs == SIZE_8) return 4;
      if ((xs == SIZE_32 && bs == SIZE_16) || (xs == SIZE_16 && bs == SIZE_8)) return 2;
      return 1;
   endfunction

   function automatic logic [1:0] model_lo(input size_t xs, input size_t bs,
                                           input logic [1:0] a, input int i);
      if (xs == SIZE_32)
      begin
         if (bs == SIZE_32) return 2'b00;
         if (bs == SIZE_16) return (i == 0) ? 2'b10 : 2'b00;
         return 2'(3 - i);                      // Descending bytes
      end
      if (xs == SIZE_16) return {a[1], bs == SIZE_8 && i == 0};
      return a;
   endfunction

   function automatic be_t model_be(input size_t xs, input size_t bs, input logic [1:0] a);
      if (bs == SIZE_8) return 4'b1110;
      if (bs == SIZE_16) return (xs != SIZE_8) ? 4'b1100 : (a[0] ? 4'b1101 : 4'b1110);
      if (xs == SIZE_8) return (a == 2'd0) ? 4'b1110 : (a == 2'd1) ? 4'b1101 :
                               (a == 2'd2) ? 4'b1011 : 4'b0111;   // Lane a low
      if (xs == SIZE_16) return a[1] ? 4'b0011 : 4'b1100;
      return 4'b0000;
   endfunction

   // Galois LFSR, one step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v = '0;
      for (int i = 0; i < n; i++)
      begin
         v = {v[30:0], lfsr[0]};
         lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
      end
      return v;
   endfunction

   // ----------------------------------------
   // APB and request drivers, bus monitor
   // ----------------------------------------
   task automatic apb_xfer(input addr_t a, input logic wr, input logic [31:0] d,
                           output logic [31:0] rd, output logic err);
      @(posedge sys_clk17) #2;
      {psel, penable, pwrite, paddr, pwdata} = {1'b1, 1'b0, wr, a, d};
      @(posedge sys_clk17) #2 penable = 1'b1;
      @(negedge sys_clk17);
      rd  = prdata;
      err = pslverr;
      check_word("pready", 32'(pready), 1);
      @(posedge sys_clk17) #2 {psel, penable} = 2'b00;
      if (wr && !err) mirror[a[2]] = '{bus_size: d[1:0], wait_states: d[7:4]};
   endtask

   task automatic set_cfg(input int b, input int bs, input int ws);
      logic [31:0] rd;
      logic err;
      apb_xfer(b ? REG_BANK1 : REG_BANK0, 1'b1, {24'h0, 4'(ws), 2'b00, 2'(bs)}, rd, err);
   endtask

   task automatic run_req(input bank_t b, input logic w, input size_t xs, input addr_t a,
                          input int fn, input be_t fbe, input logic use_file);
      bank_cfg_t c = mirror[b];                 // Config the DUT latches at accept
      int n = model_n(xs, c.bus_size);
      be_t be = model_be(xs, c.bus_size, a[1:0]);
      int k = 0, na = 0, len[4];
      addr_t seen[4];
      logic busy = 1'b0;
      if (use_file && fn != n)
      begin
         errs++;
         $display("Vector file expects %0d accesses, rules give %0d", fn, n);
      end
      if (use_file) check_be("vector n_be", fbe, be);
      @(posedge sys_clk17) #2;
      req = '{addr: a, xfer_size: xs, bank: b, write: w};
      req_valid = 1'b1;
      @(negedge sys_clk17);
      while (!req_ready) @(negedge sys_clk17);
      @(posedge sys_clk17) #2 req_valid = 1'b0;   // Accepted on this edge
      forever
      begin
         @(negedge sys_clk17);
         k++;
         if (done || k > 80) break;
         if (emi.n_cs !== 2'b11)
         begin
            if (!busy || emi.addr !== seen[na-1])
            begin
               if (na == 4)
               begin
                  errs++;
                  $display("More than four accesses in one request");
                  break;
               end
               seen[na] = emi.addr;
               len[na]  = 0;
               na++;
            end
            len[na-1]++;
            check_cs("n_cs", emi.n_cs, b ? 2'b01 : 2'b10);
            check_be("n_be", emi.n_be, be);
            check_word("n_we", 32'(emi.n_we), 32'(!w));
            check_word("n_oe", 32'(emi.n_oe), 32'(w));
         end
         busy = (emi.n_cs !== 2'b11);
      end
      if (!done) $display("done never came for request at %h", a);
      if (!done) errs++;
      if (na == 0)
      begin
         errs++;
         $display("No external access seen for request at %h", a);
      end
      else check_count("accesses minus one", acc_cnt_t'(na - 1), acc_cnt_t'(n - 1));
      for (int i = 0; i < na && i < n; i++)
      begin
         check_addr("emi.addr", seen[i], {a[31:2], model_lo(xs, c.bus_size, a[1:0], i)});
         check_word("access cycles", len[i], c.wait_states + 1);
      end
      check_word("accept to done", k, n * (c.wait_states + 1) + 1);
   endtask

   task automatic end_test(input string name, input int e0);
      tests++;
      if (errs != e0) failed++;
      $display("test %s: %s", name, (errs == e0) ? "ok" : "FAILED");
   endtask

   // ----------------------------------------
   // Main sequence
   // ----------------------------------------
   initial
   begin
      int fd, e0, c, nreq = 0;
      int b, w, s, fn;
      logic [31:0] a, fbe, rd;
      logic err;
      string line;
      {psel, penable, pwrite, req_valid} = '0;
      paddr = '0;
      pwdata = '0;
      req = '0;
      n_sys_reset17 = 1'b0;
      mirror[0] = '{bus_size: SIZE_32, wait_states: '0};
      mirror[1] = mirror[0];
      fd = $fopen("sim/smc_vectors.txt", "r");
      if (fd == 0)
      begin
         $display("Cannot open sim/smc_vectors.txt");
         $display("Regression failed");
         $finish;
      end
      while ($fgets(line, fd))
      begin
         c = line.getc(0);
         if (c != "C" && c != "R") continue;
         a = '0;
         fbe = '0;
         fn = 0;
         if (c == "C") void'($sscanf(line.substr(2, line.len() - 1), "%d %d %d", b, s, w));
         else void'($sscanf(line.substr(2, line.len() - 1), "%d %d %d %h %d %h",
                            b, w, s, a, fn, fbe));
         nreq += (c == "R");
         q_kind.push_back(c);
         q_b.push_back(b);
         q_w.push_back(w);
         q_s.push_back(s);
         q_addr.push_back(a);
         q_n.push_back(fn);
         q_be.push_back(fbe);
      end
      $fclose(fd);
      fork                                      // Watchdog
         begin
            repeat ((nreq + NRAND + 2) * (4 * 16 + 4) + 200) @(posedge sys_clk17);
            $display("Timeout: run exceeded its cycle budget");
            $display("Regression failed");
            $finish;
         end
      join_none
      repeat (10) @(posedge sys_clk17);
      #2 n_sys_reset17 = 1'b1;

      e0 = errs;                                // Reset state
      @(negedge sys_clk17);
      check_cs("n_cs", emi.n_cs, 2'b11);
      check_be("n_be", emi.n_be, 4'b1111);
      check_addr("emi.addr", emi.addr, '0);
      check_word("n_we,n_oe", {emi.n_we, emi.n_oe}, 2'b11);
      check_word("req_ready", req_ready, 1);
      apb_xfer(REG_BANK0, 1'b0, 0, rd, err);
      check_word("prdata bank0", rd, 32'h2);
      apb_xfer(REG_BANK1, 1'b0, 0, rd, err);
      check_word("prdata bank1", rd, 32'h2);
      end_test("reset_state", e0);

      e0 = errs;                                // Register access
      apb_xfer(REG_BANK0, 1'b1, 32'hffff_ff5c, rd, err);
      apb_xfer(REG_BANK0, 1'b0, 0, rd, err);
      check_word("prdata bank0", rd, 32'h50);
      apb_xfer(REG_BANK1, 1'b1, 32'h31, rd, err);
      apb_xfer(REG_BANK1, 1'b0, 0, rd, err);
      check_word("prdata bank1", rd, 32'h31);
      apb_xfer(32'h8, 1'b0, 0, rd, err);
      check_word("pslverr", err, 1);
      check_word("prdata unknown", rd, 0);
      end_test("apb_regs", e0);

      foreach (q_kind[i])
      begin
         if (q_kind[i] == "C") set_cfg(q_b[i], q_s[i], q_w[i]);
         else
         begin
            e0 = errs;
            run_req(q_b[i], q_w[i], q_s[i], q_addr[i], q_n[i], q_be[i], 1'b1);
            end_test($sformatf("vector_%0d", i), e0);
         end
      end

      e0 = errs;                                // Held request, config change mid-transfer
      set_cfg(0, 1, 5);
      fork
         run_req(1'b0, 1'b1, SIZE_32, 32'h0000_4444, 0, '0, 1'b0);
         begin
            repeat (3) @(posedge sys_clk17);
            set_cfg(0, 0, 1);
            @(posedge sys_clk17) #2;
            check_word("req_ready while busy", req_ready, 0);
            req = '{addr: 32'h0000_5556, xfer_size: SIZE_16, bank: 1'b0, write: 1'b0};
            req_valid = 1'b1;
         end
      join
      run_req(1'b0, 1'b0, SIZE_16, 32'h0000_5556, 0, '0, 1'b0);
      end_test("held_req", e0);

      for (int i = 0; i < NRAND; i++)
      begin
         if (i % 4 == 0)
         begin
            s = rand_bits(2);
            set_cfg(rand_bits(1), (s == 3) ? 2 : s, rand_bits(4));
         end
         e0 = errs;
         b = rand_bits(1);
         s = rand_bits(2);
         w = rand_bits(1);
         run_req(b, w, (s == 3) ? SIZE_8 : s, rand_bits(32), 0, '0, 1'b0);
         end_test($sformatf("random_%0d", i), e0);
      end

      $display("tests %0d, failed %0d, errors %0d", tests, failed, errs);
      if (errs == 0)
      begin
         $display("Regression passed");
      end
      else
      begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

/* sim/smc_vectors.txt */
# C bank bus_size wait_states   (size codes: 0=8, 1=16, 2=32 bit)
# R bank write xfer_size addr(hex) expected_N expected_n_be(hex)
C 0 2 0
C 1 0 1
R 0 0 2 00001000 1 0
R 0 1 1 00001002 1 3
R 0 0 1 00001000 1 c
R 0 1 0 00001003 1 7
R 0 0 0 00001001 1 d
R 1 1 2 20000000 4 e
R 1 0 1 20000002 2 e
R 1 1 0 20000003 1 e
C 0 1 2
R 0 0 2 0000abcc 2 c
R 0 1 1 0000abce 1 c
R 0 0 0 0000abcd 1 d
R 0 1 0 0000abcc 1 e
C 1 2 3
R 1 0 2 fffffff0 1 0
R 1 1 0 fffffff2 1 b
R 1 0 1 fffffff0 1 c

/* verilog/smc_access_ctrl.sv */
/* Access sequencer: one request at a time, config of the chosen bank taken at accept.
   Bus width code 2'b11 is treated as a 32-bit bus (single access). */

module smc_access_ctrl import smc_pkg::*;
(
   input  logic                        sys_clk17,
   input  logic                        n_sys_reset17,
   input  logic                        req_valid,
   input  smc_req_t                    req,
   input  bank_cfg_t [NUM_BANKS-1:0]   cfg,
   output logic                        req_ready,
   output logic                        start,
   output smc_req_t                    req_lat,
   output size_t                       bus_size,
   output smc_state_e                  next_state,
   output acc_cnt_t                    num_access,
   output logic                        step,
   output logic                        done
);

   smc_state_e state_q;
   smc_req_t   req_q;                           // Request held for the transfer
   size_t      bus_size_q;
   ws_t        ws_q;                            // Wait states of this transfer
   ws_t        ws_cnt_q;                        // Cycles left in this access
   acc_cnt_t   acc_q;                           // Accesses after the current one
   bank_cfg_t  sel_cfg;
   acc_cnt_t   first_cnt;
   logic       acc_end;

   // Accesses beyond the first, from transfer size over bus width
   function automatic acc_cnt_t extra_acc(input size_t xfer, input size_t bus);
      extra_acc = 2'd0;
      if (xfer == SIZE_32 && bus == SIZE_8)
      begin
         extra_acc = 2'd3;                      // Four byte accesses
      end
      else if ((xfer == SIZE_32 && bus == SIZE_16) || (xfer == SIZE_16 && bus == SIZE_8))
      begin
         extra_acc = 2'd1;                      // Two accesses
      end
   endfunction

   assign sel_cfg   = cfg[req.bank];
   assign first_cnt = extra_acc(req.xfer_size, sel_cfg.bus_size);

   assign req_ready = (state_q == ST_IDLE);
   assign start     = req_valid && req_ready;   // Handshake edge
   assign acc_end   = (state_q == ST_RW) && (ws_cnt_q == '0);
   assign step      = acc_end && (acc_q != '0); // Another access follows
   assign done      = (state_q == ST_DONE);

   // Live request in the accept cycle, held copy after it
   assign req_lat    = start ? req : req_q;
   assign bus_size   = start ? sel_cfg.bus_size : bus_size_q;
   assign num_access = acc_q;

   // ----------------------------------------
   // FSM
   // ----------------------------------------
   always_comb
   begin
      next_state = state_q;
      case (state_q)
         ST_IDLE:
         begin
            if (req_valid)
            begin
               next_state = ST_RW;
            end
         end
         ST_RW:
         begin
            if (acc_end && acc_q == '0)         // Last access ends
            begin
               next_state = ST_DONE;
            end
         end
         ST_DONE: next_state = ST_IDLE;
         default: next_state = ST_IDLE;
      endcase
   end

   always_ff @(posedge sys_clk17 or negedge n_sys_reset17)
   begin
      if (!n_sys_reset17)
      begin
         state_q  <= ST_IDLE;
         acc_q    <= '0;
         ws_cnt_q <= '0;
      end
      else
      begin
         state_q <= next_state;
         if (start)
         begin
            acc_q    <= first_cnt;
            ws_cnt_q <= sel_cfg.wait_states;
         end
         else if (step)
         begin
            acc_q    <= acc_q - acc_cnt_t'(1);
            ws_cnt_q <= ws_q;                   // Reload for next access
         end
         else if (state_q == ST_RW && ws_cnt_q != '0)
         begin
            ws_cnt_q <= ws_cnt_q - ws_t'(1);
         end
      end
   end

   // Transfer payload, captured at accept
   always_ff @(posedge sys_clk17)
   begin
      if (start)
      begin
         req_q      <= req;
         bus_size_q <= sel_cfg.bus_size;
         ws_q       <= sel_cfg.wait_states;
      end
   end

   // Host sees ready again only through the done cycle
   assert property (@(posedge sys_clk17) disable iff (!n_sys_reset17)
      $rose(req_ready) |-> $past(done));

endmodule

/* verilog/smc_addr_gen.sv */
/* External address, chip select and strobe registers, updated in step with the FSM.
   Little-endian lane order; multi-access words walk the low address bits downward. */

module smc_addr_gen import smc_pkg::*;
(
   input  logic        sys_clk17,
   input  logic        n_sys_reset17,
   input  logic        start,
   input  smc_req_t    req,
   input  size_t       bus_size,
   input  smc_state_e  next_state,
   input  acc_cnt_t    num_access,
   input  logic        step,
   output emi_t        emi
);

   logic [1:0] first_lo;                        // Low bits of first access
   logic [1:0] next_lo;
   be_t        n_be_dec;
   addr_t      addr_q;
   be_t        n_be_q;
   cs_t        n_cs_q;
   logic       n_we_q;
   logic       n_oe_q;

   // ----------------------------------------
   // Low address bits
   // ----------------------------------------
   always_comb
   begin
      case ({req.xfer_size, bus_size})
         {SIZE_32, SIZE_32}: first_lo = 2'b00;
         {SIZE_32, SIZE_16}: first_lo = 2'b10; // Upper half first
         {SIZE_32, SIZE_8}:  first_lo = 2'b11; // Top byte first
         {SIZE_16, SIZE_32},
         {SIZE_16, SIZE_16}: first_lo = {req.addr[1], 1'b0};
         {SIZE_16, SIZE_8}:  first_lo = {req.addr[1], 1'b1};
         default:            first_lo = req.addr[1:0];    // Byte
      endcase
   end

   // Following access, chosen by accesses still to run
   always_comb
   begin
      next_lo = addr_q[1:0];
      case ({req.xfer_size, bus_size})
         {SIZE_32, SIZE_16}: next_lo = 2'b00;
         {SIZE_32, SIZE_8}:
         begin
            case (num_access)
               2'd3:    next_lo = 2'b10;
               2'd2:    next_lo = 2'b01;
               default: next_lo = 2'b00;
            endcase
         end
         {SIZE_16, SIZE_8}:  next_lo = {req.addr[1], 1'b0};
         default:            next_lo = addr_q[1:0];  // Single access
      endcase
   end

   always_ff @(posedge sys_clk17 or negedge n_sys_reset17)
   begin
      if (!n_sys_reset17)
      begin
         addr_q <= '0;
      end
      else if (start)
      begin
         addr_q <= {req.addr[ADDR_W-1:2], first_lo};
      end
      else if (step)
      begin
         addr_q[1:0] <= next_lo;                // Upper bits hold
      end
   end

   // ----------------------------------------
   // Byte enable decode
   // ----------------------------------------
   always_comb
   begin
      n_be_dec = 4'b1111;                       // Invalid size codes
      case (bus_size)
         SIZE_8:  n_be_dec = 4'b1110;           // Lane 0 only
         SIZE_16:
         begin
            if (req.xfer_size == SIZE_8)
            begin
               n_be_dec = req.addr[0] ? 4'b1101 : 4'b1110;
            end
            else if (req.xfer_size == SIZE_16 || req.xfer_size == SIZE_32)
            begin
               n_be_dec = 4'b1100;
            end
         end
         SIZE_32:
         begin
            case (req.xfer_size)
               SIZE_8:  n_be_dec = ~(be_t'(1) << req.addr[1:0]);
               SIZE_16: n_be_dec = req.addr[1] ? 4'b0011 : 4'b1100;
               SIZE_32: n_be_dec = 4'b0000;
               default: n_be_dec = 4'b1111;
            endcase
         end
         default: n_be_dec = 4'b1111;
      endcase
   end

   // Strobes live only while the FSM is in ST_RW
   always_ff @(posedge sys_clk17 or negedge n_sys_reset17)
   begin
      if (!n_sys_reset17)
      begin
         n_cs_q <= '1;
         n_be_q <= '1;
         n_we_q <= 1'b1;
         n_oe_q <= 1'b1;
      end
      else if (next_state == ST_RW)
      begin
         n_cs_q <= ~(cs_t'(1) << req.bank);
         n_be_q <= n_be_dec;
         n_we_q <= ~req.write;
         n_oe_q <= req.write;
      end
      else
      begin
         n_cs_q <= '1;
         n_be_q <= '1;
         n_we_q <= 1'b1;
         n_oe_q <= 1'b1;
      end
   end

   assign emi = '{addr: addr_q, n_be: n_be_q, n_cs: n_cs_q, n_we: n_we_q, n_oe: n_oe_q};

   assert property (@(posedge sys_clk17) disable iff (!n_sys_reset17)
      $onehot0(~emi.n_cs));

endmodule

/* verilog/smc_apb_regs.sv */
/* APB3 config block, one word per bank: bus width in [1:0], wait states in [7:4].
   paddr is decoded in full, so nonzero upper bits give an error. No wait states. */

module smc_apb_regs import smc_pkg::*;
(
   input  logic                        sys_clk17,
   input  logic                        n_sys_reset17,
   input  logic                        psel,
   input  logic                        penable,
   input  logic                        pwrite,
   input  addr_t                       paddr,
   input  logic [31:0]                 pwdata,
   output logic [31:0]                 prdata,
   output logic                        pready,
   output logic                        pslverr,
   output bank_cfg_t [NUM_BANKS-1:0]   cfg
);

   logic hit0;                                  // Offset decodes
   logic hit1;
   logic known;
   logic wr_en;

   // Register word layout, unused bits zero
   function automatic logic [31:0] cfg_word(input bank_cfg_t c);
      cfg_word = {24'h00_0000, c.wait_states, 2'b00, c.bus_size};
   endfunction

   assign hit0  = (paddr == REG_BANK0);
   assign hit1  = (paddr == REG_BANK1);
   assign known = hit0 || hit1;
   assign wr_en = psel && penable && pwrite;    // Access phase write

   assign pready  = 1'b1;                       // Never stretches
   assign pslverr = psel && penable && !known;

   // ----------------------------------------
   // Config registers
   // ----------------------------------------
   always_ff @(posedge sys_clk17 or negedge n_sys_reset17)
   begin
      if (!n_sys_reset17)
      begin
         for (int i = 0; i < NUM_BANKS; i++)
         begin
            cfg[i] <= '{bus_size: SIZE_32, wait_states: '0};
         end
      end
      else if (wr_en && hit0)
      begin
         cfg[0] <= '{bus_size: pwdata[1:0], wait_states: pwdata[7:4]};
      end
      else if (wr_en && hit1)
      begin
         cfg[1] <= '{bus_size: pwdata[1:0], wait_states: pwdata[7:4]};
      end
   end

   // Readback mux, zero off-target
   always_comb
   begin
      prdata = 32'h0000_0000;
      if (psel && hit0)
      begin
         prdata = cfg_word(cfg[0]);
      end
      else if (psel && hit1)
      begin
         prdata = cfg_word(cfg[1]);
      end
   end

   // Error only in an access phase that followed its setup phase
   assert property (@(posedge sys_clk17) disable iff (!n_sys_reset17)
      pslverr |-> psel && penable && $past(psel && !penable));

endmodule

/* verilog/smc_pkg.sv */
/* Shared widths, size codes and bus structs for the static memory controller.
   Little-endian only; two banks, each with an 8, 16 or 32 bit data bus. */

package smc_pkg;

   // ----------------------------------------
   // Widths and counts
   // ----------------------------------------
   localparam int ADDR_W    = 32;               // Host and external address
   localparam int NUM_BANKS = 2;                // External banks
   localparam int WS_W      = 4;                // Wait-state count width

   typedef logic [ADDR_W-1:0]    addr_t;
   typedef logic                 bank_t;        // Bank index
   typedef logic [3:0]           be_t;          // Byte enables, active low
   typedef logic [NUM_BANKS-1:0] cs_t;          // Chip selects, active low
   typedef logic [1:0]           size_t;        // Transfer size or bus width
   typedef logic [1:0]           acc_cnt_t;     // Accesses still to run
   typedef logic [WS_W-1:0]      ws_t;

   // Size codes, shared by transfer size and bus width
   localparam size_t SIZE_8  = 2'b00;
   localparam size_t SIZE_16 = 2'b01;
   localparam size_t SIZE_32 = 2'b10;

   // APB register offsets
   localparam addr_t REG_BANK0 = 32'h0000_0000;
   localparam addr_t REG_BANK1 = 32'h0000_0004;

   // Access FSM
   typedef enum logic [1:0] {
      ST_IDLE,
      ST_RW,                                    // External access running
      ST_DONE                                   // One cycle after last access
   } smc_state_e;

   typedef struct packed {
      addr_t addr;
      size_t xfer_size;
      bank_t bank;
      logic  write;                             // 1 = write, 0 = read
   } smc_req_t;

   typedef struct packed {
      size_t bus_size;
      ws_t   wait_states;                       // Extra cycles per access
   } bank_cfg_t;

   // External memory bus, strobes active low
   typedef struct packed {
      addr_t addr;
      be_t   n_be;
      cs_t   n_cs;
      logic  n_we;
      logic  n_oe;
   } emi_t;

endpackage

/* verilog/smc_top.sv */
/* Controller top: APB config block, access FSM and external bus register stage.
   Config writes apply from the next accepted request. */

module smc_top import smc_pkg::*;
(
   input  logic        sys_clk17,
   input  logic        n_sys_reset17,
   // APB config port
   input  logic        psel,
   input  logic        penable,
   input  logic        pwrite,
   input  addr_t       paddr,
   input  logic [31:0] pwdata,
   output logic [31:0] prdata,
   output logic        pready,
   output logic        pslverr,
   // Host request port
   input  logic        req_valid,
   input  smc_req_t    req,
   output logic        req_ready,
   // External memory bus
   output emi_t        emi,
   output logic        done
);

   bank_cfg_t [NUM_BANKS-1:0] cfg;              // Per-bank width and waits
   logic       start;
   smc_req_t   req_lat;
   size_t      bus_size;
   smc_state_e next_state;
   acc_cnt_t   num_access;
   logic       step;

   smc_apb_regs u_apb_regs (
      .sys_clk17     (sys_clk17),
      .n_sys_reset17 (n_sys_reset17),
      .psel          (psel),
      .penable       (penable),
      .pwrite        (pwrite),
      .paddr         (paddr),
      .pwdata        (pwdata),
      .prdata        (prdata),
      .pready        (pready),
      .pslverr       (pslverr),
      .cfg           (cfg)
   );

   smc_access_ctrl u_access_ctrl (
      .sys_clk17     (sys_clk17),
      .n_sys_reset17 (n_sys_reset17),
      .req_valid     (req_valid),
      .req           (req),
      .cfg           (cfg),
      .req_ready     (req_ready),
      .start         (start),
      .req_lat       (req_lat),
      .bus_size      (bus_size),
      .next_state    (next_state),
      .num_access    (num_access),
      .step          (step),
      .done          (done)
   );

   smc_addr_gen u_addr_gen (
      .sys_clk17     (sys_clk17),
      .n_sys_reset17 (n_sys_reset17),
      .start         (start),
      .req           (req_lat),
      .bus_size      (bus_size),
      .next_state    (next_state),
      .num_access    (num_access),
      .step          (step),
      .emi           (emi)
   );

endmodule
